// File: cpuTypesPkg.sv
package cpuTypesPkg;

	// ------------------------------
	// Datapath widths
	// ------------------------------
	localparam int DataWidth = 8;
	localparam int AddrWidth = 16;	// Fixed by the instruction set
	localparam int RegIdxWidth = 3;

	typedef logic [DataWidth-1:0] dataT;
	typedef logic [AddrWidth-1:0] addrT;
	typedef logic [RegIdxWidth-1:0] regIdxT;

	// ------------------------------
	// Register operand codes
	// ------------------------------
	// Same encoding as the r and r' fields of the opcode
	localparam regIdxT regB = 3'd0;
	localparam regIdxT regC = 3'd1;
	localparam regIdxT regD = 3'd2;
	localparam regIdxT regE = 3'd3;
	localparam regIdxT regH = 3'd4;
	localparam regIdxT regL = 3'd5;
	localparam regIdxT regHlMem = 3'd6;	// (HL) memory operand
	localparam regIdxT regA = 3'd7;

	// Opcode bits 5:3, destination or ALU operation
	function automatic regIdxT opY(dataT op);
		return op[5:3];
	endfunction

	// Opcode bits 2:0, source operand
	function automatic regIdxT opZ(dataT op);
		return op[2:0];
	endfunction

endpackage

// File: ucodePkg.sv
package ucodePkg;

	typedef enum logic [3:0]
	{
		uNop, uFetch, uReadImm, uReadHl, uWriteHl, uMove, uAlu,
		uInc16, uDec16, uLoadTmpLo, uLoadTmpHi, uJump, uJumpZ, uHalt
	} uCmdT;

	typedef logic [15:0] uopT;
	typedef logic [5:0] uPcT;

	// ------------------------------
	// Micro-op field layout
	// ------------------------------
	localparam int UopCmdLsb = 0;	// 4 bits
	localparam int UopRegLsb = 4;	// 3 bits
	localparam int UopEofBit = 7;
	localparam int UopSrcOpBit = 8;	// Register fields come from the opcode
	// Bits 15:9 stay zero

	function automatic uopT mkUop(uCmdT cmd, logic [2:0] regField, logic eof, logic srcOp);
		uopT u;
		u = '0;
		u[UopCmdLsb +: 4] = cmd;
		u[UopRegLsb +: 3] = regField;
		u[UopEofBit] = eof;
		u[UopSrcOpBit] = srcOp;
		return u;
	endfunction

	function automatic uCmdT uopCmd(uopT u);
		return uCmdT'(u[UopCmdLsb +: 4]);
	endfunction

	function automatic logic [2:0] uopReg(uopT u);
		return u[UopRegLsb +: 3];
	endfunction

	typedef enum logic [1:0] {stReset, stRun, stBusWait, stHalted} ctrlStateT;

	typedef enum logic [1:0] {aluAdd, aluAnd, aluXor, aluPass} aluOpT;

endpackage

// File: ucodeRom.sv
module ucodeRom
(
	input  ucodePkg::uPcT     uPc,
	input  cpuTypesPkg::dataT opcode,
	output ucodePkg::uopT     uop,
	output ucodePkg::uPcT     flowStart
);
	import cpuTypesPkg::*;
	import ucodePkg::*;

	// Flow entry points
	localparam uPcT FlowFetch = 6'd0;
	localparam uPcT FlowNop = 6'd1;
	localparam uPcT FlowHalt = 6'd2;
	localparam uPcT FlowLdImm = 6'd3;
	localparam uPcT FlowMove = 6'd4;
	localparam uPcT FlowLdRHl = 6'd5;
	localparam uPcT FlowLdHlR = 6'd6;
	localparam uPcT FlowAlu = 6'd7;
	localparam uPcT FlowInc16 = 6'd8;
	localparam uPcT FlowDec16 = 6'd9;
	localparam uPcT FlowJp = 6'd10;		// Three micro-ops
	localparam uPcT FlowJpZ = 6'd13;	// Three micro-ops

	// ------------------------------
	// Micro-op flows
	// ------------------------------
	always_comb
	begin
		case (uPc)
			FlowFetch:       uop = mkUop(uFetch, regA, 1'b0, 1'b0);
			FlowNop:         uop = mkUop(uNop, regA, 1'b1, 1'b0);
			FlowHalt:        uop = mkUop(uHalt, regA, 1'b1, 1'b0);
			FlowLdImm:       uop = mkUop(uReadImm, regA, 1'b1, 1'b1);
			FlowMove:        uop = mkUop(uMove, regA, 1'b1, 1'b1);
			FlowLdRHl:       uop = mkUop(uReadHl, regA, 1'b1, 1'b1);
			FlowLdHlR:       uop = mkUop(uWriteHl, regA, 1'b1, 1'b1);
			FlowAlu:         uop = mkUop(uAlu, regA, 1'b1, 1'b1);	// Result back to A
			FlowInc16:       uop = mkUop(uInc16, regH, 1'b1, 1'b0);
			FlowDec16:       uop = mkUop(uDec16, regH, 1'b1, 1'b0);
			FlowJp:          uop = mkUop(uLoadTmpLo, regA, 1'b0, 1'b0);
			FlowJp + 6'd1:   uop = mkUop(uLoadTmpHi, regA, 1'b0, 1'b0);
			FlowJp + 6'd2:   uop = mkUop(uJump, regA, 1'b1, 1'b0);
			FlowJpZ:         uop = mkUop(uLoadTmpLo, regA, 1'b0, 1'b0);
			FlowJpZ + 6'd1:  uop = mkUop(uLoadTmpHi, regA, 1'b0, 1'b0);
			FlowJpZ + 6'd2:  uop = mkUop(uJumpZ, regA, 1'b1, 1'b0);
			default:         uop = mkUop(uNop, regA, 1'b1, 1'b0);	// Stray address ends the flow
		endcase
	end

	// ------------------------------
	// Opcode map
	// ------------------------------
	always_comb
	begin
		flowStart = FlowNop;	// Unknown opcodes run as NOP
		casez (opcode)
			8'h00:       flowStart = FlowNop;
			8'h76:       flowStart = FlowHalt;
			8'b00???110:
			begin
				// LD (HL),n is not supported
				if (opY(opcode) != regHlMem)
					flowStart = FlowLdImm;
			end
			8'b01???110: flowStart = FlowLdRHl;
			8'b01110???: flowStart = FlowLdHlR;
			8'b01??????: flowStart = FlowMove;
			8'b10000???, 8'b10100???, 8'b10101???:
			begin
				if (opZ(opcode) != regHlMem)
					flowStart = FlowAlu;
			end
			8'h23:       flowStart = FlowInc16;
			8'h2B:       flowStart = FlowDec16;
			8'hC3:       flowStart = FlowJp;
			8'hCA:       flowStart = FlowJpZ;
			default:     flowStart = FlowNop;
		endcase
	end

endmodule

// File: cpuControl.sv
module cpuControl
#(
	parameter cpuTypesPkg::addrT ResetVector = 16'h0000
)
(
	input  logic                iClock,
	input  logic                rst,
	input  ucodePkg::uopT       uop,
	input  ucodePkg::uPcT       flowStart,
	input  logic                busDone,
	input  cpuTypesPkg::dataT   busRdData,
	input  cpuTypesPkg::dataT   rdDataA,
	input  cpuTypesPkg::dataT   rdDataB,
	input  cpuTypesPkg::addrT   hlValue,
	input  cpuTypesPkg::dataT   aluResult,
	input  logic                aluZero,
	input  cpuTypesPkg::addrT   wordResult,
	output ucodePkg::uPcT       uPc,
	output cpuTypesPkg::dataT   opcode,
	output logic                busStart,
	output logic                busWe,
	output cpuTypesPkg::addrT   busAddr,
	output cpuTypesPkg::dataT   busWrData,
	output cpuTypesPkg::regIdxT rdIdxA,
	output cpuTypesPkg::regIdxT rdIdxB,
	output logic                wrEn,
	output cpuTypesPkg::regIdxT wrIdx,
	output cpuTypesPkg::dataT   wrData,
	output logic                hlWrEn,
	output cpuTypesPkg::addrT   hlWrData,
	output ucodePkg::aluOpT     aluOp,
	output cpuTypesPkg::dataT   aluA,
	output cpuTypesPkg::dataT   aluB,
	output cpuTypesPkg::addrT   wordIn,
	output logic                wordDec,
	output logic                halted
);
	import cpuTypesPkg::*;
	import ucodePkg::*;

	ctrlStateT state;
	addrT pc;
	dataT opcodeReg;
	addrT jumpTarget;
	logic zeroFlag;

	uCmdT cmd;
	logic eof;
	logic srcOp;
	regIdxT srcIdx;
	regIdxT dstIdx;
	logic isBusOp;
	logic busFinish;	// Bus micro-op completes this cycle
	logic stepDone;		// Current micro-op retires this cycle
	logic fetchDone;

	// ------------------------------
	// Micro-op decode
	// ------------------------------
	assign cmd = uopCmd(uop);
	assign eof = uop[UopEofBit];
	assign srcOp = uop[UopSrcOpBit];
	assign srcIdx = srcOp ? opZ(opcodeReg) : uopReg(uop);
	assign dstIdx = (srcOp && cmd != uAlu) ? opY(opcodeReg) : uopReg(uop);	// ALU writes the field

	assign isBusOp = cmd inside {uFetch, uReadImm, uReadHl, uWriteHl, uLoadTmpLo, uLoadTmpHi};
	assign busFinish = (state == stBusWait) && busDone;
	assign stepDone = ((state == stRun) && !isBusOp && cmd != uHalt) || busFinish;
	assign fetchDone = busFinish && (cmd == uFetch);

	// Fresh opcode goes straight to the map, dispatch costs no cycle
	assign opcode = fetchDone ? busRdData : opcodeReg;

	assign busStart = (state == stRun) && isBusOp;
	assign busWe = (cmd == uWriteHl);
	assign busAddr = (cmd inside {uReadHl, uWriteHl}) ? hlValue : pc;
	assign busWrData = rdDataB;

	// Datapath controls
	assign rdIdxA = uopReg(uop);	// Accumulator for ALU ops
	assign rdIdxB = srcIdx;
	assign aluA = rdDataA;
	assign aluB = rdDataB;
	assign wrIdx = dstIdx;
	assign wrEn = ((state == stRun) && (cmd inside {uMove, uAlu}))
		|| (busFinish && (cmd inside {uReadImm, uReadHl}));
	assign wrData = (state == stBusWait) ? busRdData : aluResult;
	assign wordIn = hlValue;
	assign wordDec = (cmd == uDec16);
	assign hlWrEn = (state == stRun) && (cmd inside {uInc16, uDec16});
	assign hlWrData = wordResult;
	assign halted = (state == stHalted);

	always_comb
	begin
		aluOp = aluPass;	// LD r,r' passes operand B
		if (cmd == uAlu)
		begin
			case (opY(opcodeReg))
				3'b000:  aluOp = aluAdd;
				3'b100:  aluOp = aluAnd;
				3'b101:  aluOp = aluXor;
				default: aluOp = aluPass;
			endcase
		end
	end

	// ------------------------------
	// Sequencer
	// ------------------------------
	always_ff @(posedge iClock)
	begin
		if (rst)
		begin
			state <= stReset;
			uPc <= '0;
			pc <= ResetVector;
			opcodeReg <= '0;
			zeroFlag <= 1'b0;
		end
		else
		begin
			case (state)
				stReset: state <= stRun;
				stRun:
				begin
					if (cmd == uHalt)
						state <= stHalted;
					else if (isBusOp)
						state <= stBusWait;
				end
				stBusWait:
				begin
					if (busDone)
						state <= stRun;
				end
				default: state <= stHalted;	// Held until rst
			endcase

			if (stepDone)
			begin
				if (fetchDone)
					uPc <= flowStart;
				else if (eof)
					uPc <= '0;	// Back to fetch
				else
					uPc <= uPc + 1'b1;
			end

			if (busFinish && (cmd inside {uFetch, uReadImm, uLoadTmpLo, uLoadTmpHi}))
				pc <= pc + 1'b1;
			else if ((state == stRun) && (cmd == uJump || (cmd == uJumpZ && zeroFlag)))
				pc <= jumpTarget;

			if (fetchDone)
				opcodeReg <= busRdData;

			if ((state == stRun) && (cmd == uAlu))
				zeroFlag <= aluZero;
			else if (hlWrEn)
				zeroFlag <= (wordResult == '0);
		end
	end

	// Jump target, little endian operand
	always_ff @(posedge iClock)
	begin
		if (busFinish && cmd == uLoadTmpLo)
			jumpTarget[7:0] <= busRdData;
		if (busFinish && cmd == uLoadTmpHi)
			jumpTarget[15:8] <= busRdData;
	end

endmodule

// File: registerFile.sv
module registerFile
(
	input  logic                iClock,
	input  logic                rst,
	input  cpuTypesPkg::regIdxT rdIdxA,
	input  cpuTypesPkg::regIdxT rdIdxB,
	input  logic                wrEn,
	input  cpuTypesPkg::regIdxT wrIdx,
	input  cpuTypesPkg::dataT   wrData,
	input  logic                hlWrEn,
	input  cpuTypesPkg::addrT   hlWrData,
	output cpuTypesPkg::dataT   rdDataA,
	output cpuTypesPkg::dataT   rdDataB,
	output cpuTypesPkg::addrT   hlValue
);
	import cpuTypesPkg::*;

	localparam int NumRegs = 7;
	localparam int SlotA = 6;	// A takes the slot left free by (HL)

	dataT regs [NumRegs];

	function automatic int slotOf(regIdxT idx);
		return (idx == regA) ? SlotA : int'(idx);
	endfunction

	// ------------------------------
	// Read ports
	// ------------------------------
	// (HL) operands travel over the bus, so index 6 reads as zero
	assign rdDataA = (rdIdxA == regHlMem) ? '0 : regs[slotOf(rdIdxA)];
	assign rdDataB = (rdIdxB == regHlMem) ? '0 : regs[slotOf(rdIdxB)];
	assign hlValue = {regs[slotOf(regH)], regs[slotOf(regL)]};

	// ------------------------------
	// Write ports
	// ------------------------------
	always_ff @(posedge iClock)
	begin
		if (rst)
		begin
			for (int i = 0; i < NumRegs; i++)
				regs[i] <= '0;
		end
		else
		begin
			if (wrEn && wrIdx != regHlMem)
				regs[slotOf(wrIdx)] <= wrData;

			// Pair update for INC HL and DEC HL
			if (hlWrEn)
			begin
				regs[slotOf(regH)] <= hlWrData[15:8];
				regs[slotOf(regL)] <= hlWrData[7:0];
			end
		end
	end

endmodule

// File: aluUnit.sv
module aluUnit
(
	input  ucodePkg::aluOpT   aluOp,
	input  cpuTypesPkg::dataT aluA,
	input  cpuTypesPkg::dataT aluB,
	input  cpuTypesPkg::addrT wordIn,
	input  logic              wordDec,
	output cpuTypesPkg::dataT aluResult,
	output logic              aluZero,
	output cpuTypesPkg::addrT wordResult,
	output logic              wordZero
);
	import ucodePkg::*;

	// ------------------------------
	// Byte operations
	// ------------------------------
	always_comb
	begin
		case (aluOp)
			aluAdd:  aluResult = aluA + aluB;	// Carry out is dropped
			aluAnd:  aluResult = aluA & aluB;
			aluXor:  aluResult = aluA ^ aluB;
			default: aluResult = aluB;		// Pass
		endcase
	end

	assign aluZero = (aluResult == '0);

	// ------------------------------
	// Word operations
	// ------------------------------
	// Wraps at both ends of the 16-bit range
	assign wordResult = wordDec ? (wordIn - 1'b1) : (wordIn + 1'b1);
	assign wordZero = (wordResult == '0);

endmodule

// File: memBusPort.sv
module memBusPort
(
	input  logic              iClock,
	input  logic              rst,
	input  logic              busStart,
	input  logic              busWe,
	input  cpuTypesPkg::addrT busAddr,
	input  cpuTypesPkg::dataT busWrData,
	input  logic              memAck,
	input  cpuTypesPkg::dataT memRdData,
	output logic              busDone,
	output cpuTypesPkg::dataT busRdData,
	output logic              memReq,
	output logic              memWe,
	output cpuTypesPkg::addrT memAddr,
	output cpuTypesPkg::dataT memWrData
);
	typedef enum logic [1:0] {busIdle, busRequest, busRelease} busStateT;

	busStateT state;

	// Four-phase handshake
	always_ff @(posedge iClock)
	begin
		if (rst)
		begin
			state <= busIdle;
			memReq <= 1'b0;
			memWe <= 1'b0;
			busDone <= 1'b0;
		end
		else
		begin
			busDone <= 1'b0;
			case (state)
				busIdle:
				begin
					if (busStart)
					begin
						memReq <= 1'b1;
						memWe <= busWe;
						state <= busRequest;
					end
				end
				busRequest:
				begin
					if (memAck)
					begin
						memReq <= 1'b0;
						memWe <= 1'b0;
						state <= busRelease;
					end
				end
				busRelease:
				begin
					if (!memAck)
					begin
						busDone <= 1'b1;	// Memory has let go of ack
						state <= busIdle;
					end
				end
				default: state <= busIdle;
			endcase
		end
	end

	// Request fields and captured read byte
	always_ff @(posedge iClock)
	begin
		if (state == busIdle && busStart)
		begin
			memAddr <= busAddr;
			memWrData <= busWrData;
		end
		if (state == busRequest && memAck)
			busRdData <= memRdData;
	end

endmodule

// File: cpuCore.sv
module cpuCore
#(
	parameter cpuTypesPkg::addrT ResetVector = 16'h0000
)
(
	input  logic              iClock,
	input  logic              rst,
	output logic              memReq,
	output logic              memWe,
	output cpuTypesPkg::addrT memAddr,
	output cpuTypesPkg::dataT memWrData,
	input  logic              memAck,
	input  cpuTypesPkg::dataT memRdData,
	output logic              halted
);
	import cpuTypesPkg::*;
	import ucodePkg::*;

	// ------------------------------
	// Internal nets
	// ------------------------------
	uopT uop;
	uPcT uPc;
	uPcT flowStart;
	dataT opcode;
	logic busStart;
	logic busWe;
	logic busDone;
	addrT busAddr;
	dataT busWrData;
	dataT busRdData;
	regIdxT rdIdxA;
	regIdxT rdIdxB;
	regIdxT wrIdx;
	logic wrEn;
	dataT wrData;
	dataT rdDataA;
	dataT rdDataB;
	logic hlWrEn;
	addrT hlWrData;
	addrT hlValue;
	aluOpT aluOp;
	dataT aluA;
	dataT aluB;
	dataT aluResult;
	logic aluZero;
	addrT wordIn;
	logic wordDec;
	addrT wordResult;

	cpuControl #(.ResetVector(ResetVector)) u_cpuControl (.*);

	registerFile u_registerFile (.*);

	aluUnit u_aluUnit (.wordZero(), .*);	// Control tests the word result itself

	ucodeRom u_ucodeRom (.*);

	memBusPort u_memBusPort (.*);

endmodule

// File: cpuCore_checker.sv
module cpuCore_checker
(
	input logic              iClock,
	input logic              rst,
	input logic              memReq,
	input logic              memWe,
	input cpuTypesPkg::addrT memAddr,
	input logic              memAck
);
	int violations = 0;	// Count of failed assertions

	// ------------------------------
	// Four-phase bus rules
	// ------------------------------
	reqHeld: assert property (@(posedge iClock) disable iff (rst)
		memReq && !memAck |=> memReq)
	else
	begin
		violations++;
		$error("memReq dropped before memAck");
	end

	// Request fields frozen while the request is up
	fieldsStable: assert property (@(posedge iClock) disable iff (rst)
		memReq |=> !memReq || ($stable(memAddr) && $stable(memWe)))
	else
	begin
		violations++;
		$error("memAddr or memWe changed while memReq was high");
	end

	noReqDuringAck: assert property (@(posedge iClock) disable iff (rst)
		memAck |-> !$rose(memReq))
	else
	begin
		violations++;
		$error("memReq rose while memAck was high");
	end

endmodule

// File: tbClockGen.sv
module tbClockGen
#(
	parameter int Period = 100,
	parameter int ResetCycles = 16
)
(
	input  logic restart,
	output logic iClock,
	output logic rst
);
	int count = 0;
	logic rstReg = 1'b1;	// Asserted from time zero

	assign rst = rstReg;

	initial
	begin
		iClock = 1'b0;
		forever
			#(Period / 2) iClock = ~iClock;
	end

	// Reset spans ResetCycles edges at start and after each restart
	always @(posedge iClock)
	begin
		if (restart)
		begin
			rstReg <= 1'b1;
			count <= 0;
		end
		else if (count < ResetCycles - 1)
			count <= count + 1;
		else
			rstReg <= 1'b0;
	end

endmodule

// File: tbCpuCore.sv
module tbCpuCore;
	import cpuTypesPkg::*;

	localparam addrT ResetVector = 16'h0100;
	localparam int NumTests = 7;
	localparam int NumPasses = 2;		// Second pass sees other memory latencies
	localparam int HaltTimeout = 3000;
	localparam int IdleCycles = 20;
	localparam logic [15:0] LfsrSeed = 16'd63550;

	typedef struct packed
	{
		logic [0:15][7:0] prog;	// Byte 0 lands at ResetVector
		addrT wrAddr;
		dataT wrData;
		logic [7:0] wrCount;
	} testT;

	// Program, last write address, last write data, number of writes
	localparam testT Tests [NumTests] = '{
		'{128'h3E5A2612_2E347776_76767676_76767676, 16'h1234, 8'h5A, 8'd1},	// LD r,n and store
		'{128'h3EC80664_8026202E_00777676_76767676, 16'h2000, 8'h2C, 8'd1},	// ADD wraps mod 256
		'{128'h3EF0063C_A026202E_1077A877_76767676, 16'h2010, 8'h0C, 8'd2},	// AND then XOR
		'{128'h3E7726FF_2EFF2377_2B777676_76767676, 16'hFFFF, 8'h77, 8'd2},	// INC and DEC HL
		'{128'h26232E45_46782E46_77767676_76767676, 16'h2346, 8'hC1, 8'd1},	// LD B,(HL), LD A,B
		'{128'h3E112630_2E00C30A_01773E22_77767676, 16'h3000, 8'h22, 8'd1},	// JP skips a store
		'{128'h3E0F060F_A0CA0A01_77A8CA0E_01777676, 16'h0000, 8'h0F, 8'd1}	// JP Z both ways
	};

	logic iClock;
	logic rst;
	logic restart = 1'b0;
	logic memReq;
	logic memWe;
	addrT memAddr;
	dataT memWrData;
	logic memAck = 1'b0;
	dataT memRdData = '0;
	logic halted;

	dataT mem [65536];
	logic pending;
	logic [2:0] waitLeft;
	logic [2:0] drawnDelay;
	logic [15:0] lfsrState = LfsrSeed;
	int writeCount;
	addrT lastWrAddr;
	dataT lastWrData;

	tbClockGen u_clockGen (.restart(restart), .iClock(iClock), .rst(rst));

	cpuCore #(.ResetVector(ResetVector)) u_cpuCore (.*);

	bind memBusPort cpuCore_checker u_busChecker (.*);

	function automatic logic [15:0] lfsrNext(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};	// x^16 + x^14 + x^13 + x^11 + 1
	endfunction

	task automatic drawDelay(output logic [2:0] d);
		for (int i = 0; i < 3; i++)
		begin
			d[i] = lfsrState[15];
			lfsrState = lfsrNext(lfsrState);
		end
	endtask

	function automatic dataT fillByte(addrT a);
		return a[7:0] ^ a[15:8] ^ 8'hA7;
	endfunction

	task automatic abortRun(string reason);
		$display("%s", reason);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
		if (actual !== expected)
			abortRun($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected));
	endtask

	// ------------------------------
	// Memory model
	// ------------------------------
	always @(posedge iClock)
	begin
		if (rst)
		begin
			memAck <= 1'b0;
			pending <= 1'b0;
			writeCount <= 0;
			lastWrAddr <= '0;
			lastWrData <= '0;
		end
		else if (memReq && !memAck)
		begin
			if (!pending)
			begin
				drawDelay(drawnDelay);	// 0 to 7 extra cycles
				waitLeft <= drawnDelay;
				pending <= 1'b1;
			end
			else if (waitLeft != 0)
				waitLeft <= waitLeft - 1'b1;
			else
			begin
				if (memWe)
				begin
					mem[memAddr] = memWrData;
					writeCount <= writeCount + 1;
					lastWrAddr <= memAddr;
					lastWrData <= memWrData;
				end
				else
					memRdData <= mem[memAddr];
				memAck <= 1'b1;
			end
		end
		else if (!memReq && memAck)
		begin
			memAck <= 1'b0;	// Request withdrawn, close the handshake
			pending <= 1'b0;
		end
	end

	// Stop at the first bus protocol violation
	always @(posedge iClock)
	begin
		if (u_cpuCore.u_memBusPort.u_busChecker.violations != 0)
			abortRun("A bus protocol assertion failed");
	end

	// ------------------------------
	// One table entry
	// ------------------------------
	task automatic runTest(testT entry);
		int cycles;
		@(posedge iClock);
		restart <= 1'b1;
		@(posedge iClock);
		restart <= 1'b0;
		cycles = 0;
		do
		begin
			@(negedge iClock);
			cycles++;
		end
		while (!rst && cycles < 10);
		if (!rst)
			abortRun("Reset did not assert after a restart request");

		for (int a = 0; a < 65536; a++)
			mem[a] = fillByte(addrT'(a));
		for (int i = 0; i < 16; i++)
			mem[ResetVector + i] = entry.prog[i];

		cycles = 0;
		while (rst && cycles < 40)
		begin
			@(negedge iClock);
			cycles++;
		end
		if (rst)
			abortRun("Reset was never released");
		checkValue("halted", halted, 0);

		// First fetch two cycles after reset falls
		cycles = 0;
		while (!memReq && cycles < 10)
		begin
			cycles++;
			@(negedge iClock);
		end
		checkValue("first memReq delay", cycles, 2);
		checkValue("memAddr", memAddr, ResetVector);
		checkValue("memWe", memWe, 0);

		cycles = 0;
		while (!halted && cycles < HaltTimeout)
		begin
			@(negedge iClock);
			cycles++;
		end
		if (!halted)
			abortRun("Timed out waiting for the core to halt");

		for (int i = 0; i < IdleCycles; i++)
		begin
			@(negedge iClock);
			checkValue("memReq", memReq, 0);
			checkValue("halted", halted, 1);
		end
		checkValue("writeCount", writeCount, entry.wrCount);
		checkValue("lastWrAddr", lastWrAddr, entry.wrAddr);
		checkValue("lastWrData", lastWrData, entry.wrData);
	endtask

	initial
	begin
		for (int pass = 0; pass < NumPasses; pass++)
		begin
			for (int t = 0; t < NumTests; t++)
				runTest(Tests[t]);
		end
		if (u_cpuCore.u_memBusPort.u_busChecker.violations == 0)
		begin
			$display("Everything OK");
			$finish;
		end
		else
			abortRun("Bus protocol assertions failed during the run");
	end

endmodule

// File: cpuCore.f
cpuTypesPkg.sv
ucodePkg.sv
ucodeRom.sv
cpuControl.sv
registerFile.sv
aluUnit.sv
memBusPort.sv
cpuCore.sv
cpuCore_checker.sv
tbClockGen.sv
tbCpuCore.sv

// File: Bender.yml
package:
  name: cpuCore

sources:
  - files:
      - cpuTypesPkg.sv
      - ucodePkg.sv
      - ucodeRom.sv
      - cpuControl.sv
      - registerFile.sv
      - aluUnit.sv
      - memBusPort.sv
      - cpuCore.sv
  - target: test
    files:
      - cpuCore_checker.sv
      - tbClockGen.sv
      - tbCpuCore.sv
